// ==== Bender.yml ====
package:
  name: mem_wb

sources:
  - files:
      - hdl/rv32i_pkg.sv
      - hdl/lsu_pkg.sv
      - hdl/stage_reg.sv
      - hdl/byte_lane_align.sv
      - hdl/mem_wait_timer.sv
      - hdl/mem_access_fsm.sv
      - hdl/data_ram.sv
      - hdl/write_back.sv
      - hdl/mem_wb_top.sv
  - target: test
    files:
      - bench/mem_wb_tb.sv

// ==== bench/mem_wb_tb.sv ====
`default_nettype none

module mem_wb_tb;

    localparam int MEM_LATENCY   = 3;
    localparam int RAM_WORDS     = 256;
    localparam int AW            = $clog2(RAM_WORDS);
    localparam int N_ALU         = 24;
    localparam int N_PAIRS       = 4;
    localparam int LANE_WORDS    = 8;
    localparam int N_LANE_STORES = 16;
    localparam int N_ITEMS = N_ALU + 4 * N_PAIRS + LANE_WORDS + N_LANE_STORES + 13 * LANE_WORDS;
    localparam int TIMEOUT = 40 * N_ITEMS + 200;

    logic                clk;
    logic                rst_n;
    lsu_pkg::mem_stage_t in_item;
    logic                in_valid;
    logic                in_ready;
    lsu_pkg::wb_t        out_rec;
    lsu_pkg::wb_t        prev_out;
    logic                out_valid;
    logic                out_ready;

    rv32i_pkg::rv32i_word model_mem [RAM_WORDS];
    lsu_pkg::wb_t         exp_q [$];
    lsu_pkg::wb_t         exp_head;
    int                   exp_pending     = 0;
    logic                 accepted_any    = 1'b0;
    int                   cycle           = 0;
    int                   value_errors    = 0;
    int                   protocol_errors = 0;

    mem_wb_top #(.MEM_LATENCY(MEM_LATENCY), .RAM_WORDS(RAM_WORDS)) i_dut (
        .clk, .rst_n, .in(in_item), .in_valid, .in_ready,
        .out(out_rec), .out_valid, .out_ready
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle     <= cycle + 1;
        prev_out  <= out_rec;
        out_ready <= $urandom_range(9, 0) < 7;  // ready on about seven cycles in ten.
    end

    function automatic lsu_pkg::wb_t expect_record(lsu_pkg::mem_stage_t it);
        lsu_pkg::wb_t         rec;
        rv32i_pkg::rv32i_word word;
        logic [7:0]           b;
        logic [15:0]          h;
        word             = model_mem[it.alu_out[2 +: AW]];
        b                = word[8 * it.alu_out[1:0] +: 8];
        h                = word[16 * it.alu_out[1] +: 16];
        rec.load_regfile = it.ctrl.load_regfile;
        rec.rd           = it.ctrl.rd;
        case (it.ctrl.regfilemux_sel)
            rv32i_pkg::br_en:    rec.rd_data = {31'b0, it.br_en};
            rv32i_pkg::u_imm:    rec.rd_data = it.ctrl.u_imm;
            rv32i_pkg::pc_plus4: rec.rd_data = it.pc_plus4;
            rv32i_pkg::lw:       rec.rd_data = word;
            rv32i_pkg::lb:       rec.rd_data = {{24{b[7]}}, b};
            rv32i_pkg::lbu:      rec.rd_data = {24'b0, b};
            rv32i_pkg::lh:       rec.rd_data = {{16{h[15]}}, h};
            rv32i_pkg::lhu:      rec.rd_data = {16'b0, h};
            default:             rec.rd_data = it.alu_out;
        endcase
        return rec;
    endfunction

    task automatic model_store(lsu_pkg::mem_stage_t it);
        logic [AW-1:0] w;
        logic [1:0]    off;
        w   = it.alu_out[2 +: AW];
        off = it.alu_out[1:0];
        case (it.ctrl.mem_width)
            rv32i_pkg::width_byte: model_mem[w][8 * off +: 8] = it.store_data[7:0];
            rv32i_pkg::width_half: model_mem[w][16 * off[1] +: 16] = it.store_data[15:0];
            default:               model_mem[w] = it.store_data;
        endcase
    endtask

    // expected records are queued in input order and retired on each output transfer.
    always @(posedge clk)
    begin
        if (rst_n && out_valid && out_ready && exp_q.size() != 0)
            void'(exp_q.pop_front());
        if (rst_n && in_valid && in_ready)
        begin
            exp_q.push_back(expect_record(in_item));
            if (in_item.ctrl.mem_op == rv32i_pkg::store)
                model_store(in_item);
            accepted_any <= 1'b1;
        end
        exp_pending <= exp_q.size();
        if (exp_q.size() != 0)
            exp_head <= exp_q[0];
    end

    a_record: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready && exp_pending != 0 |-> out_rec == exp_head)
    else
    begin
        value_errors++;
        $display("CHECK FAILED t=%0t out expected %h got %h", $time,
                 $sampled(exp_head), $sampled(out_rec));
    end

    a_expected: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready |-> exp_pending != 0)
    else
    begin
        protocol_errors++;
        $display("t=%0t an output record arrived with no input left to match it", $time);
    end

    a_stall: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_rec))
    else
    begin
        value_errors++;
        $display("CHECK FAILED t=%0t out (stalled) expected %h got %h", $time,
                 $sampled(prev_out), $sampled(out_rec));
    end

    a_quiet: assert property (@(posedge clk) cycle != 0 && !accepted_any |-> !out_valid)
    else
    begin
        protocol_errors++;
        $display("t=%0t out_valid went high before any item was accepted", $time);
    end

    function automatic lsu_pkg::mem_stage_t random_item();
        lsu_pkg::mem_stage_t it;
        it.ctrl.load_regfile   = 1'($urandom);
        it.ctrl.rd             = 5'($urandom);
        it.ctrl.regfilemux_sel = rv32i_pkg::alu_out;
        it.ctrl.mem_op         = rv32i_pkg::none;
        it.ctrl.mem_width      = rv32i_pkg::width_byte;
        it.ctrl.u_imm          = $urandom;
        it.alu_out             = $urandom;
        it.br_en               = 1'($urandom);
        it.pc_plus4            = $urandom;
        it.store_data          = $urandom;
        return it;
    endfunction

    function automatic lsu_pkg::mem_stage_t mem_item(
        rv32i_pkg::rv32i_word addr, rv32i_pkg::mem_op_t op,
        rv32i_pkg::mem_width_t width, rv32i_pkg::regfilemux_sel_t sel
    );
        lsu_pkg::mem_stage_t it;
        it                     = random_item();
        it.alu_out             = addr;
        it.ctrl.mem_op         = op;
        it.ctrl.mem_width      = width;
        it.ctrl.regfilemux_sel = sel;
        return it;
    endfunction

    task automatic send_item(lsu_pkg::mem_stage_t it);
        int gap;
        gap = ($urandom_range(1, 0) == 0) ? 0 : $urandom_range(4, 1);
        repeat (gap) @(posedge clk);
        in_item  <= it;
        in_valid <= 1'b1;
        do
            @(posedge clk);
        while (!in_ready);
        in_valid <= 1'b0;
    endtask

    task automatic finish_run(input bit hung);
        $display("errors: value %0d, protocol %0d, records still expected %0d",
                 value_errors, protocol_errors, exp_q.size());
        if (!hung && value_errors == 0 && protocol_errors == 0 && exp_q.size() == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    endtask

    initial
    begin
        while (cycle < TIMEOUT)
            @(posedge clk);
        $display("run stopped after %0d cycles, the DUT seems to hang", cycle);
        finish_run(1'b1);
    end

    initial
    begin
        lsu_pkg::mem_stage_t it;
        int                  w;
        void'($urandom(32'hea33f364));
        rst_n     <= 1'b0;
        in_valid  <= 1'b0;
        in_item   <= '0;
        out_ready <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < N_ALU; i++)
        begin
            it = random_item();
            case (i % 4)
                0:       it.ctrl.regfilemux_sel = rv32i_pkg::alu_out;
                1:       it.ctrl.regfilemux_sel = rv32i_pkg::br_en;
                2:       it.ctrl.regfilemux_sel = rv32i_pkg::u_imm;
                default: it.ctrl.regfilemux_sel = rv32i_pkg::pc_plus4;
            endcase
            send_item(it);
        end

        // the second lw must still see the first word after the store next door.
        for (int i = 0; i < N_PAIRS; i++)
        begin
            send_item(mem_item(32'(128 + 8 * i), rv32i_pkg::store, rv32i_pkg::width_word,
                               rv32i_pkg::alu_out));
            send_item(mem_item(32'(128 + 8 * i), rv32i_pkg::load, rv32i_pkg::width_word,
                               rv32i_pkg::lw));
            send_item(mem_item(32'(132 + 8 * i), rv32i_pkg::store, rv32i_pkg::width_word,
                               rv32i_pkg::alu_out));
            send_item(mem_item(32'(128 + 8 * i), rv32i_pkg::load, rv32i_pkg::width_word,
                               rv32i_pkg::lw));
        end

        for (int i = 0; i < LANE_WORDS; i++)
            send_item(mem_item(32'(4 * i), rv32i_pkg::store, rv32i_pkg::width_word,
                               rv32i_pkg::alu_out));
        for (int i = 0; i < N_LANE_STORES; i++)
        begin
            w = $urandom_range(LANE_WORDS - 1, 0);
            if ($urandom_range(1, 0) == 1)
                it = mem_item(32'(4 * w) + $urandom_range(3, 0), rv32i_pkg::store,
                              rv32i_pkg::width_byte, rv32i_pkg::alu_out);
            else
                it = mem_item(32'(4 * w) + 2 * $urandom_range(1, 0), rv32i_pkg::store,
                              rv32i_pkg::width_half, rv32i_pkg::alu_out);
            send_item(it);
        end
        for (int i = 0; i < LANE_WORDS; i++)
        begin
            for (int b = 0; b < 4; b++)
            begin
                send_item(mem_item(32'(4 * i + b), rv32i_pkg::load, rv32i_pkg::width_byte,
                                   rv32i_pkg::lb));
                send_item(mem_item(32'(4 * i + b), rv32i_pkg::load, rv32i_pkg::width_byte,
                                   rv32i_pkg::lbu));
            end
            for (int h = 0; h < 2; h++)
            begin
                send_item(mem_item(32'(4 * i + 2 * h), rv32i_pkg::load, rv32i_pkg::width_half,
                                   rv32i_pkg::lh));
                send_item(mem_item(32'(4 * i + 2 * h), rv32i_pkg::load, rv32i_pkg::width_half,
                                   rv32i_pkg::lhu));
            end
            send_item(mem_item(32'(4 * i), rv32i_pkg::load, rv32i_pkg::width_word,
                               rv32i_pkg::lw));
        end

        // drain, then keep watching for stray records.
        @(posedge clk);
        while (exp_pending != 0)
            @(posedge clk);
        repeat (20) @(posedge clk);
        finish_run(1'b0);
    end

endmodule

`default_nettype wire

// ==== hdl/byte_lane_align.sv ====
`default_nettype none

module byte_lane_align (
    input  logic                   [1:0] addr_low,
    input  rv32i_pkg::mem_width_t        width,
    input  rv32i_pkg::rv32i_word         store_data,
    output logic                   [3:0] byte_en,
    output rv32i_pkg::rv32i_word         lane_data
);

    always_comb
    begin
        case (width)
            rv32i_pkg::width_byte:
            begin
                byte_en   = 4'b0001 << addr_low;
                lane_data = {4{store_data[7:0]}};
            end
            rv32i_pkg::width_half:
            begin
                byte_en   = addr_low[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{store_data[15:0]}};  // both halves carry the low half.
            end
            default:
            begin
                byte_en   = 4'b1111;
                lane_data = store_data;
            end
        endcase
    end

    // misaligned accesses are not supported by the memory stage.
    // case equality keeps an empty, unknown item from tripping the check.
    always_comb
    begin
        a_aligned: assert final (!((width === rv32i_pkg::width_half && addr_low[0] === 1'b1) ||
                                   (width === rv32i_pkg::width_word && addr_low !== 2'b00)));
    end

endmodule

`default_nettype wire

// ==== hdl/data_ram.sv ====
`default_nettype none

module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic                 clk,
    input  lsu_pkg::dmem_req_t   req,
    input  logic                 req_strobe,
    output rv32i_pkg::rv32i_word rdata
);

    localparam int AW = $clog2(RAM_WORDS);

    rv32i_pkg::rv32i_word mem [RAM_WORDS];
    logic [AW-1:0]        idx;

    assign idx = req.word_addr[AW-1:0];  // upper address bits wrap.

    always_ff @(posedge clk)
    begin
        if (req_strobe && req.write)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (req.byte_en[b])
                    mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_strobe && !req.write)
            rdata <= mem[idx];  // held until the next load.
    end

endmodule

`default_nettype wire

// ==== hdl/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // one instruction as it leaves the execute stage.
    typedef struct packed {
        rv32i_pkg::rv32i_control_word ctrl;
        rv32i_pkg::rv32i_word         alu_out;    // result, or the byte address.
        logic                         br_en;
        rv32i_pkg::rv32i_word         pc_plus4;
        rv32i_pkg::rv32i_word         store_data;
    } mem_stage_t;

    // one record for the register file.
    typedef struct packed {
        logic                 load_regfile;
        rv32i_pkg::rv32i_reg  rd;
        rv32i_pkg::rv32i_word rd_data;
    } wb_t;

    // request to the data memory, valid with its strobe.
    typedef struct packed {
        rv32i_pkg::rv32i_word word_addr;  // byte address shifted right by two.
        logic                 write;
        logic [3:0]           byte_en;
        rv32i_pkg::rv32i_word wdata;
    } dmem_req_t;

endpackage

`default_nettype wire

// ==== hdl/mem_access_fsm.sv ====
`default_nettype none

module mem_access_fsm (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    item_valid,
    output logic                    item_ready,
    input  lsu_pkg::mem_stage_t     item,
    input  logic              [3:0] byte_en,
    input  rv32i_pkg::rv32i_word    lane_data,
    output lsu_pkg::dmem_req_t      req,
    output logic                    req_strobe,
    input  rv32i_pkg::rv32i_word    rdata,
    output logic                    timer_start,
    input  logic                    timer_done,
    output lsu_pkg::mem_stage_t     wb_item,
    output rv32i_pkg::rv32i_word    wb_rdata,
    output logic              [3:0] wb_byte_en,
    output logic                    wb_valid,
    input  logic                    wb_ready
);

    typedef enum logic [1:0] {
        s_idle,
        s_wait,
        s_offer
    } state_t;

    state_t state;
    logic   is_mem;

    assign is_mem = item.ctrl.mem_op != rv32i_pkg::none;

    assign item_ready  = state == s_idle;
    assign req_strobe  = item_valid && item_ready && is_mem;
    assign timer_start = req_strobe;  // every access is timed from its strobe.
    assign wb_valid    = state == s_offer;

    assign req.word_addr = {2'b00, item.alu_out[31:2]};
    assign req.write     = item.ctrl.mem_op == rv32i_pkg::store;
    assign req.byte_en   = byte_en;
    assign req.wdata     = lane_data;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= s_idle;
        else
        begin
            case (state)
                s_idle:
                    if (item_valid)
                        state <= is_mem ? s_wait : s_offer;
                s_wait:
                    if (timer_done)
                        state <= s_offer;
                default:
                    if (wb_ready)
                        state <= s_idle;
            endcase
        end
    end

    // the item and its lanes are kept for write-back; read data lands on done.
    always_ff @(posedge clk)
    begin
        if (item_valid && item_ready)
        begin
            wb_item    <= item;
            wb_byte_en <= byte_en;
        end
        if (state == s_wait && timer_done)
            wb_rdata <= rdata;
    end

    // the timer only finishes an access that is still waiting for it.
    a_done_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        timer_done |-> state == s_wait);

endmodule

`default_nettype wire

// ==== hdl/mem_wait_timer.sv ====
`default_nettype none

module mem_wait_timer #(
    parameter int MEM_LATENCY = 3
) (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic done
);

    localparam int CW = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

    logic          busy;
    logic [CW-1:0] count;

    assign done = busy && (count == '0);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            busy <= 1'b0;
        else if (start)
            busy <= 1'b1;
        else if (done)
            busy <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (start)
            count <= CW'(MEM_LATENCY - 1);
        else if (busy && !done)
            count <= count - 1'b1;
    end

    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy);

endmodule

`default_nettype wire

// ==== hdl/mem_wb_top.sv ====
`default_nettype none

module mem_wb_top #(
    parameter int MEM_LATENCY = 3,  // at least one.
    parameter int RAM_WORDS   = 256
) (
    input  logic                clk,
    input  logic                rst_n,
    input  lsu_pkg::mem_stage_t in,
    input  logic                in_valid,
    output logic                in_ready,
    output lsu_pkg::wb_t        out,
    output logic                out_valid,
    input  logic                out_ready
);

    lsu_pkg::mem_stage_t  s_item;
    logic                 s_valid;
    logic                 s_ready;
    logic [3:0]           byte_en;
    rv32i_pkg::rv32i_word lane_data;
    lsu_pkg::dmem_req_t   req;
    logic                 req_strobe;
    rv32i_pkg::rv32i_word rdata;
    logic                 timer_start;
    logic                 timer_done;
    lsu_pkg::mem_stage_t  wb_item;
    rv32i_pkg::rv32i_word wb_rdata;
    logic [3:0]           wb_byte_en;
    logic                 wb_valid;
    logic                 wb_ready;
    lsu_pkg::wb_t         wb_rec;

    stage_reg #(.payload_t(lsu_pkg::mem_stage_t)) i_in_reg (
        .clk, .rst_n,
        .in_valid, .in_ready, .in,
        .out_valid(s_valid), .out_ready(s_ready), .out(s_item)
    );

    byte_lane_align i_align (
        .addr_low(s_item.alu_out[1:0]), .width(s_item.ctrl.mem_width),
        .store_data(s_item.store_data), .byte_en, .lane_data
    );

    mem_wait_timer #(.MEM_LATENCY(MEM_LATENCY)) i_timer (
        .clk, .rst_n, .start(timer_start), .done(timer_done)
    );

    mem_access_fsm i_fsm (
        .clk, .rst_n,
        .item_valid(s_valid), .item_ready(s_ready), .item(s_item),
        .byte_en, .lane_data, .req, .req_strobe, .rdata,
        .timer_start, .timer_done,
        .wb_item, .wb_rdata, .wb_byte_en, .wb_valid, .wb_ready
    );

    data_ram #(.RAM_WORDS(RAM_WORDS)) i_ram (
        .clk, .req, .req_strobe, .rdata
    );

    write_back i_wb (
        .item(wb_item), .rdata(wb_rdata), .byte_en(wb_byte_en), .wb(wb_rec)
    );

    stage_reg #(.payload_t(lsu_pkg::wb_t)) i_out_reg (
        .clk, .rst_n,
        .in_valid(wb_valid), .in_ready(wb_ready), .in(wb_rec),
        .out_valid, .out_ready, .out
    );

endmodule

`default_nettype wire

// ==== hdl/rv32i_pkg.sv ====
`default_nettype none

package rv32i_pkg;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;

    // source of the value written to the register file.
    typedef enum logic [3:0] {
        alu_out  = 4'd0,
        br_en    = 4'd1,
        u_imm    = 4'd2,
        lw       = 4'd3,
        lb       = 4'd4,
        lbu      = 4'd5,
        lh       = 4'd6,
        lhu      = 4'd7,
        pc_plus4 = 4'd8
    } regfilemux_sel_t;

    typedef enum logic [1:0] {
        none  = 2'd0,
        load  = 2'd1,
        store = 2'd2
    } mem_op_t;

    // width_byte must also be used for items that do not touch memory.
    typedef enum logic [1:0] {
        width_byte = 2'd0,
        width_half = 2'd1,
        width_word = 2'd2
    } mem_width_t;

    typedef struct packed {
        logic            load_regfile;
        rv32i_reg        rd;
        regfilemux_sel_t regfilemux_sel;
        mem_op_t         mem_op;
        mem_width_t      mem_width;
        rv32i_word       u_imm;
    } rv32i_control_word;

endpackage

`default_nettype wire

// ==== hdl/stage_reg.sv ====
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out
);

    logic     full;
    logic     running;  // low until the first cycle after reset.
    payload_t data;

    assign in_ready  = running && (!full || out_ready);
    assign out_valid = full;
    assign out       = data;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            running <= 1'b0;
            full    <= 1'b0;
        end
        else
        begin
            running <= 1'b1;
            if (in_valid && in_ready)
                full <= 1'b1;
            else if (out_ready)
                full <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
            data <= in;
    end

    // a stalled item must not move or change until it is taken.
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out));

endmodule

`default_nettype wire

// ==== hdl/write_back.sv ====
`default_nettype none

module write_back (
    input  lsu_pkg::mem_stage_t        item,
    input  rv32i_pkg::rv32i_word       rdata,
    input  logic                 [3:0] byte_en,
    output lsu_pkg::wb_t               wb
);

    logic [7:0]           lane_byte;
    logic [15:0]          lane_half;
    rv32i_pkg::rv32i_word regfilemux_out;

    // pick the byte and the half that the enables point at.
    always_comb
    begin
        case (byte_en)
            4'b0010: lane_byte = rdata[15:8];
            4'b0100: lane_byte = rdata[23:16];
            4'b1000: lane_byte = rdata[31:24];
            default: lane_byte = rdata[7:0];
        endcase
    end

    always_comb
    begin
        if (byte_en == 4'b1100)
            lane_half = rdata[31:16];
        else
            lane_half = rdata[15:0];  // only aligned halves reach here.
    end

    always_comb
    begin
        case (item.ctrl.regfilemux_sel)
            rv32i_pkg::alu_out:
                regfilemux_out = item.alu_out;
            rv32i_pkg::br_en:
                regfilemux_out = {31'b0, item.br_en};
            rv32i_pkg::u_imm:
                regfilemux_out = item.ctrl.u_imm;
            rv32i_pkg::lw:
                regfilemux_out = rdata;
            rv32i_pkg::lb:
                regfilemux_out = {{24{lane_byte[7]}}, lane_byte};
            rv32i_pkg::lbu:
                regfilemux_out = {24'b0, lane_byte};
            rv32i_pkg::lh:
                regfilemux_out = {{16{lane_half[15]}}, lane_half};
            rv32i_pkg::lhu:
                regfilemux_out = {16'b0, lane_half};
            rv32i_pkg::pc_plus4:
                regfilemux_out = item.pc_plus4;
            default:
                regfilemux_out = item.alu_out;
        endcase
    end

    assign wb.load_regfile = item.ctrl.load_regfile;
    assign wb.rd           = item.ctrl.rd;
    assign wb.rd_data      = regfilemux_out;

endmodule

`default_nettype wire

// ==== list.f ====
hdl/rv32i_pkg.sv
hdl/lsu_pkg.sv
hdl/stage_reg.sv
hdl/byte_lane_align.sv
hdl/mem_wait_timer.sv
hdl/mem_access_fsm.sv
hdl/data_ram.sv
hdl/write_back.sv
hdl/mem_wb_top.sv
bench/mem_wb_tb.sv
